// ==== snd_defines.svh ====
/*
 * Sound board build constants
 * work RAM and PCM ROM address widths
 * PCM voice register offsets
 */
`ifndef SND_DEFINES_SVH
`define SND_DEFINES_SVH

// 2 KB of work RAM
`define SND_RAMW 11

// PCM sample ROM, 64 KB
`define PCM_AW 16

// voice registers, low two CPU address bits
`define VOICE_START_LO 2'd0
`define VOICE_START_HI 2'd1
`define VOICE_LEN      2'd2
`define VOICE_CTRL     2'd3

`endif

// ==== snd_pkg.sv ====
/*
 * Shared types of the sound board
 * sound CPU bus cycle, chip selects, bank control byte,
 * write byte union, ROM addresses and the sample word
 */
`default_nettype none

`include "snd_defines.svh"

package snd_pkg;

    // one sound CPU bus cycle, strobes active high
    typedef struct packed {
        logic [15:0] addr;
        logic        mreq;
        logic        rd;
        logic        wr;
        logic [7:0]  dout;
    } cpu_bus_t;

    // one bit per decoded target
    typedef struct packed {
        logic rom;
        logic ram;
        logic voice;
        logic latch;
        logic bank_we;  // xmen only
        logic nmi_clr;  // xmen=0 only
    } chip_sel_t;

    typedef struct packed {
        logic [2:0] unused;
        logic       nmi_clr;
        logic [3:0] bank;
    } bank_ctrl_t;

    // the CPU write byte, seen as data or as bank control
    typedef union packed {
        logic [7:0] raw;
        bank_ctrl_t ctrl;
    } snd_wdata_u;

    typedef logic [16:0]         rom_addr_t;
    typedef logic [`PCM_AW-1:0]  pcm_addr_t;
    typedef logic signed [15:0]  snd_sample_t;

endpackage

`default_nettype wire

// ==== snd_cmd_latch.sv ====
/*
 * Command latch between the main CPU and the sound CPU
 * two command bytes written by the main CPU
 * one reply byte written back by the sound CPU
 * pending interrupt, set by command 0, cleared when it is read
 */
`default_nettype none

module snd_cmd_latch (
    input  wire       clk,
    input  wire       rst,
    input  wire [1:0] main_addr,
    input  wire [7:0] main_dout,
    input  wire       main_we,
    output wire [7:0] pair_dout,
    input  wire       cs,
    input  wire       we,
    input  wire       re,
    input  wire [1:0] addr,
    input  wire [7:0] din,
    output logic [7:0] dout,
    output wire       irq_n
);
    logic [7:0] cmd0, cmd1, reply;
    logic       pending;
    logic       set_irq, clr_irq;

    assign set_irq   = main_we && main_addr == 2'd0;
    assign clr_irq   = cs && re && addr == 2'd0;
    assign irq_n     = ~pending;
    assign pair_dout = reply;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd0    <= 8'd0;
            cmd1    <= 8'd0;
            reply   <= 8'd0;
            pending <= 1'b0;
        end else begin
            if (main_we && main_addr == 2'd0) cmd0 <= main_dout;
            if (main_we && main_addr == 2'd1) cmd1 <= main_dout;
            if (cs && we && addr == 2'd2) reply <= din;  // answer to main CPU
            // a new command wins over the acknowledge
            if (set_irq)
                pending <= 1'b1;
            else if (clr_irq)
                pending <= 1'b0;
        end
    end

    always_comb begin
        case (addr)
            2'd0:    dout = cmd0;
            2'd1:    dout = cmd1;
            2'd2:    dout = reply;
            default: dout = 8'hff;
        endcase
    end

    // no interrupt may leak out of reset
    a_irq_after_rst: assert property (@(posedge clk) $fell(rst) |-> irq_n);

endmodule

`default_nettype wire

// ==== snd_ram.sv ====
/*
 * Sound CPU work RAM
 * single port, byte wide, registered read data
 */
`default_nettype none

`include "snd_defines.svh"

module snd_ram (
    input  wire                 clk,
    input  wire                 we,
    input  wire [`SND_RAMW-1:0] addr,
    input  wire [7:0]           din,
    output logic [7:0]          dout
);
    logic [7:0] mem [0:(1<<`SND_RAMW)-1];

    // read before write on the same address
    always_ff @(posedge clk) begin
        if (we) mem[addr] <= din;
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== snd_pcm_voice.sv ====
/*
 * Single PCM channel
 * start address, length and control registers on the CPU bus
 * fetches one ROM byte per cen_pcm while playing, stalls on pcm_ok
 * sample pulse per accepted byte, end pulse after the last one
 */
`default_nettype none

`include "snd_defines.svh"

module snd_pcm_voice (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen_pcm,
    input  wire                     cs,
    input  wire                     we,
    input  wire [1:0]               addr,
    input  wire [7:0]               din,
    output logic [7:0]              dout,
    output wire [`PCM_AW-1:0]       pcm_addr,
    output logic                    pcm_cs,
    input  wire [7:0]               pcm_data,
    input  wire                     pcm_ok,
    output snd_pkg::snd_sample_t    snd,
    output logic                    sample,
    output logic                    play_end
);
    import snd_pkg::*;

    pcm_addr_t  start_addr, cur_addr;
    logic [7:0] len, cnt;
    logic       busy;
    logic       reg_we, start, fetch;

    assign reg_we   = cs && we;
    assign start    = reg_we && addr == `VOICE_CTRL && din[0];
    assign fetch    = cen_pcm && pcm_cs && pcm_ok;
    assign pcm_addr = cur_addr;

    always_ff @(posedge clk) begin
        if (reg_we && addr == `VOICE_START_LO) start_addr[7:0]  <= din;
        if (reg_we && addr == `VOICE_START_HI) start_addr[15:8] <= din;
        if (reg_we && addr == `VOICE_LEN)      len              <= din;
        if (start)
            cur_addr <= start_addr;
        else if (fetch)
            cur_addr <= cur_addr + 1'd1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            pcm_cs   <= 1'b0;
            cnt      <= 8'd0;
            snd      <= '0;
            sample   <= 1'b0;
            play_end <= 1'b0;
        end else begin
            sample   <= 1'b0;
            play_end <= 1'b0;
            if (start) begin
                busy   <= len != 8'd0;  // zero length plays nothing
                pcm_cs <= len != 8'd0;
                cnt    <= len;
            end else if (fetch) begin
                snd    <= {pcm_data, 8'd0};
                sample <= 1'b1;
                cnt    <= cnt - 1'd1;
                if (cnt == 8'd1) pcm_cs <= 1'b0;   // last byte taken
            end else if (busy && !pcm_cs) begin
                busy     <= 1'b0;
                play_end <= 1'b1;
                snd      <= '0;
            end
        end
    end

    always_comb begin
        case (addr)
            `VOICE_START_LO: dout = start_addr[7:0];
            `VOICE_START_HI: dout = start_addr[15:8];
            `VOICE_LEN:      dout = len;
            default:         dout = {7'd0, busy};
        endcase
    end

    a_cs_busy: assert property (@(posedge clk) disable iff (rst) pcm_cs |-> busy);
    a_no_overlap: assert property (@(posedge clk) disable iff (rst) !(sample && play_end));

endmodule

`default_nettype wire

// ==== snd_map.sv ====
/*
 * Sound CPU address map
 * decoding for both board variants, picked by xmen
 * ROM bank register and banked ROM address
 * NMI edge latch with its clear sources
 * read data multiplexer
 */
`default_nettype none

`include "snd_defines.svh"

module snd_map (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  xmen,
    input  snd_pkg::cpu_bus_t    bus,
    output snd_pkg::chip_sel_t   sel,
    output snd_pkg::rom_addr_t   rom_addr,
    input  wire [7:0]            rom_data,
    input  wire [7:0]            ram_dout,
    input  wire [7:0]            voice_dout,
    input  wire [7:0]            latch_dout,
    output logic [7:0]           cpu_din,
    input  wire                  nmi_trig,
    output logic                 nmi_n
);
    import snd_pkg::*;

    snd_wdata_u wdata;
    logic [3:0] bank;
    logic       nmi_clrr;
    logic [2:0] rom_hi;
    logic       upper4k;
    logic       trig_l, nmi_clr;

    assign wdata.raw = bus.dout;
    assign upper4k   = &bus.addr[15:12];

    always_comb begin
        sel = '0;
        if (!xmen) begin
            sel.rom     = bus.mreq && bus.rd && !upper4k;            // 0000-EFFF
            sel.ram     = bus.mreq && bus.addr[15:`SND_RAMW] == 5'h1e;
            sel.voice   = bus.mreq && upper4k && bus.addr[11:9] == 3'd5;
            sel.nmi_clr = bus.mreq && bus.wr && upper4k && bus.addr[11:9] == 3'd6;
            sel.latch   = bus.mreq && upper4k && bus.addr[11:9] == 3'd7;
        end else begin
            sel.rom     = bus.mreq && bus.rd && !(bus.addr[15] && bus.addr[14]);
            sel.ram     = bus.mreq && bus.addr[15:13] == 3'b110;     // 2 KB mirrored
            sel.voice   = bus.mreq && bus.addr[15:11] == 5'b11101;
            sel.latch   = bus.mreq && bus.addr[15:11] == 5'b11110;
            sel.bank_we = bus.mreq && bus.wr && bus.addr[15:10] == 6'b111110;
        end
    end

    // 8000-BFFF goes through the bank, 0000-7FFF is fixed
    assign rom_hi   = bus.addr[15] ? bank[2:0] : {2'b0, bus.addr[14]};
    assign rom_addr = xmen ? {rom_hi, bus.addr[13:0]} : {1'b0, bus.addr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= 4'd0;
            nmi_clrr <= 1'b0;
        end else if (sel.bank_we) begin
            bank     <= wdata.ctrl.bank;
            nmi_clrr <= wdata.ctrl.nmi_clr;
        end
    end

    assign nmi_clr = xmen ? nmi_clrr : sel.nmi_clr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_l <= 1'b0;
            nmi_n  <= 1'b1;
        end else begin
            trig_l <= nmi_trig;
            if (nmi_clr)
                nmi_n <= 1'b1;      // clear beats a new edge
            else if (nmi_trig && !trig_l)
                nmi_n <= 1'b0;
        end
    end

    always_comb begin
        if (sel.rom)
            cpu_din = rom_data;
        else if (sel.ram)
            cpu_din = ram_dout;
        else if (sel.voice)
            cpu_din = voice_dout;
        else if (sel.latch)
            cpu_din = latch_dout;
        else
            cpu_din = 8'hff;    // open bus
    end

    a_one_sel: assert property (@(posedge clk) disable iff (rst) $onehot0(sel));

endmodule

`default_nettype wire

// ==== snd_board.sv ====
/*
 * Sound board top level
 * address map, command latch, work RAM and PCM voice
 * interrupt and NMI sources picked by the board variant
 */
`default_nettype none

`include "snd_defines.svh"

module snd_board (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen_pcm,
    input  wire                  xmen,
    input  wire                  snd_irq,
    input  wire [1:0]            main_addr,
    input  wire [7:0]            main_dout,
    input  wire                  main_we,
    output wire [7:0]            pair_dout,
    input  snd_pkg::cpu_bus_t    bus,
    output wire [7:0]            cpu_din,
    output snd_pkg::rom_addr_t   rom_addr,
    output wire                  rom_cs,
    input  wire [7:0]            rom_data,
    output wire [`PCM_AW-1:0]    pcm_addr,
    output wire                  pcm_cs,
    input  wire [7:0]            pcm_data,
    input  wire                  pcm_ok,
    output snd_pkg::snd_sample_t snd,
    output wire                  int_n,
    output wire                  nmi_n
);
    import snd_pkg::*;

    chip_sel_t  sel;
    logic [7:0] ram_dout, voice_dout, latch_dout;
    logic       latch_irq_n, sample, play_end, nmi_trig;

    assign rom_cs   = sel.rom;
    assign int_n    = xmen ? latch_irq_n : ~snd_irq;
    assign nmi_trig = xmen ? play_end : sample;

    snd_map snd_map_i (
        .clk        (clk),
        .rst        (rst),
        .xmen       (xmen),
        .bus        (bus),
        .sel        (sel),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .ram_dout   (ram_dout),
        .voice_dout (voice_dout),
        .latch_dout (latch_dout),
        .cpu_din    (cpu_din),
        .nmi_trig   (nmi_trig),
        .nmi_n      (nmi_n)
    );

    snd_cmd_latch snd_cmd_latch_i (
        .clk       (clk),
        .rst       (rst),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .main_we   (main_we),
        .pair_dout (pair_dout),
        .cs        (sel.latch),
        .we        (bus.wr),
        .re        (bus.rd),
        .addr      (bus.addr[1:0]),
        .din       (bus.dout),
        .dout      (latch_dout),
        .irq_n     (latch_irq_n)
    );

    // RAM mirrors every 2 KB in the xmen map
    snd_ram snd_ram_i (
        .clk  (clk),
        .we   (sel.ram && bus.wr),
        .addr (bus.addr[`SND_RAMW-1:0]),
        .din  (bus.dout),
        .dout (ram_dout)
    );

    snd_pcm_voice snd_pcm_voice_i (
        .clk      (clk),
        .rst      (rst),
        .cen_pcm  (cen_pcm),
        .cs       (sel.voice),
        .we       (bus.wr),
        .addr     (bus.addr[1:0]),
        .din      (bus.dout),
        .dout     (voice_dout),
        .pcm_addr (pcm_addr),
        .pcm_cs   (pcm_cs),
        .pcm_data (pcm_data),
        .pcm_ok   (pcm_ok),
        .snd      (snd),
        .sample   (sample),
        .play_end (play_end)
    );

endmodule

`default_nettype wire

// ==== tb_snd_board.sv ====
/*
 * Testbench for the sound board top level
 * program and PCM ROM models, clock, reset and random PCM handshake
 * reference model of work RAM, command latch, bank and voice playback
 * compare tasks and a cycle limit
 */
`default_nettype none

`include "snd_defines.svh"

module tb_snd_board;
    timeunit 1ns;
    timeprecision 1ps;

    import snd_pkg::*;

    localparam int MAX_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        rst;
    logic        cen_pcm = 1'b0;
    logic        pcm_ok = 1'b0;
    logic        xmen, snd_irq, main_we;
    logic [1:0]  main_addr;
    logic [7:0]  main_dout, pair_dout, cpu_din, rom_data, pcm_data;
    cpu_bus_t    bus;
    rom_addr_t   rom_addr;
    pcm_addr_t   pcm_addr;
    logic        rom_cs, pcm_cs, int_n, nmi_n;
    snd_sample_t snd;

    integer      seed = 3;
    int          cycles = 0;
    logic        pcm_run = 1'b0;    // lets the random cen_pcm through
    logic [31:0] pcm_rnd;
    rom_addr_t   last_rom_addr;
    logic        last_rom_cs;

    // reference model state
    logic [7:0]  ram_m [0:(1<<`SND_RAMW)-1];
    logic [7:0]  cmd_m [0:1];
    logic [7:0]  reply_m = 8'h00;
    logic [3:0]  bank_m = 4'd0;
    logic        pend_m = 1'b0;

    snd_board snd_board_i (
        .clk(clk), .rst(rst), .cen_pcm(cen_pcm), .xmen(xmen), .snd_irq(snd_irq),
        .main_addr(main_addr), .main_dout(main_dout), .main_we(main_we),
        .pair_dout(pair_dout), .bus(bus), .cpu_din(cpu_din),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .pcm_addr(pcm_addr), .pcm_cs(pcm_cs), .pcm_data(pcm_data), .pcm_ok(pcm_ok),
        .snd(snd), .int_n(int_n), .nmi_n(nmi_n)
    );

    function automatic logic [7:0] rom_byte(input rom_addr_t a);
        return a[7:0] ^ a[16:9];
    endfunction

    function automatic logic [7:0] pcm_byte(input pcm_addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    assign rom_data = rom_byte(rom_addr);
    assign pcm_data = pcm_byte(pcm_addr);

    always #20 clk = ~clk;

    // pcm_ok high about 3 times in 4
    always @(posedge clk) begin
        #5;
        pcm_rnd = $random(seed);
        cen_pcm = pcm_run & pcm_rnd[0];
        pcm_ok  = pcm_rnd[3:2] != 2'b00;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
            stop_on_error($sformatf("timeout after %0d cycles, tests did not finish", cycles));
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_rom_addr(input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR %0t rom_addr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_pcm_addr(input pcm_addr_t got, input pcm_addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR %0t pcm_addr got %h expected %h", $time, got, exp));
    endtask

    task automatic check_sample(input snd_sample_t got, input snd_sample_t exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR %0t snd got %h expected %h", $time, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    // every access is held for two clocks, called at posedge + 5
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        bus.addr = a;
        bus.mreq = 1'b1;
        bus.rd   = 1'b0;
        bus.wr   = 1'b1;
        bus.dout = d;
        repeat (2) @(posedge clk);
        #5;
        bus = '0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        bus.addr = a;
        bus.mreq = 1'b1;
        bus.rd   = 1'b1;
        bus.wr   = 1'b0;
        bus.dout = 8'h00;
        @(posedge clk);
        #30;                // late in the second cycle
        d = cpu_din;
        last_rom_addr = rom_addr;
        last_rom_cs   = rom_cs;
        @(posedge clk);
        #5;
        bus = '0;
    endtask

    task automatic main_write(input logic [1:0] a, input logic [7:0] d);
        main_addr = a;
        main_dout = d;
        main_we   = 1'b1;
        @(posedge clk);
        #5;
        main_we = 1'b0;
    endtask

    task automatic ram_write_read;
        logic [10:0] q[$];
        logic [10:0] off;
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  d;
        for (int mode = 0; mode < 2; mode++) begin
            xmen = mode[0];
            q.delete();
            repeat (32) begin
                r = $random(seed);
                off = r[10:0];
                a = xmen ? {3'b110, r[12:11], off} : {5'b11110, off};  // aliases in xmen map
                bus_write(a, r[23:16]);
                ram_m[off] = r[23:16];
                q.push_back(off);
            end
            repeat (32) begin
                r = $random(seed);
                off = q[r[15:0] % q.size()];
                a = xmen ? {3'b110, r[17:16], off} : {5'b11110, off};
                bus_read(a, d);
                check_byte("cpu_din", d, ram_m[off]);
            end
        end
    endtask

    task automatic rom_window_reads;
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  d;
        rom_addr_t   exp;
        xmen = 1'b0;
        repeat (24) begin
            r = $random(seed);
            a = r[15:0];
            if (a[15:12] == 4'hf)
                a[12] = 1'b0;
            bus_read(a, d);
            check_flag("rom_cs", last_rom_cs, 1'b1);
            check_rom_addr(last_rom_addr, {1'b0, a});
            check_byte("cpu_din", d, rom_byte({1'b0, a}));
        end
        repeat (8) begin
            r = $random(seed);
            bus_read({5'b11111, r[9], 1'b0, r[8:0]}, d);   // F800-F9FF or FC00-FDFF
            check_flag("rom_cs", last_rom_cs, 1'b0);
            check_byte("cpu_din", d, 8'hff);
        end
        xmen = 1'b1;
        repeat (6) begin
            r = $random(seed);
            bus_write({6'b111110, r[25:16]}, {r[7:5], 1'b0, r[3:0]});
            bank_m = r[3:0];
            repeat (6) begin
                r = $random(seed);
                a = r[15:0];
                if (a[15:14] == 2'b11)
                    a[15] = 1'b0;
                exp = {a[15] ? bank_m[2:0] : {2'b00, a[14]}, a[13:0]};
                bus_read(a, d);
                check_flag("rom_cs", last_rom_cs, 1'b1);
                check_rom_addr(last_rom_addr, exp);
                check_byte("cpu_din", d, rom_byte(exp));
            end
            r = $random(seed);
            bus_read(r[11] ? {5'b11111, r[10:0]} : {5'b11100, r[10:0]}, d);
            check_byte("cpu_din", d, 8'hff);
        end
    endtask

    task automatic latch_exchange;
        logic [31:0] r;
        logic [7:0]  d;
        xmen = 1'b1;
        repeat (40) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: begin
                    main_write({1'b0, r[8]}, r[23:16]);
                    cmd_m[r[8]] = r[23:16];
                    if (!r[8])
                        pend_m = 1'b1;
                end
                2'd1: begin
                    bus_read({5'b11110, r[17:9], 1'b0, r[8]}, d);
                    check_byte("cpu_din", d, cmd_m[r[8]]);
                    if (!r[8])
                        pend_m = 1'b0;  // reading command 0 acknowledges
                end
                2'd2: begin
                    bus_write({5'b11110, r[17:9], 2'd2}, r[23:16]);
                    reply_m = r[23:16];
                end
                default: begin
                    bus_read({5'b11110, r[17:9], 1'b1, r[8]}, d);
                    check_byte("cpu_din", d, r[8] ? 8'hff : reply_m);
                end
            endcase
            @(negedge clk);
            check_flag("int_n", int_n, ~pend_m);
            check_byte("pair_dout", pair_dout, reply_m);
            @(posedge clk);
            #5;
        end
        xmen = 1'b0;
        bus_read(16'hfe01, d);
        check_byte("cpu_din", d, cmd_m[1]);
        repeat (16) begin
            r = $random(seed);
            snd_irq = r[0];
            @(negedge clk);
            check_flag("int_n", int_n, ~r[0]);
            @(posedge clk);
            #5;
        end
        snd_irq = 1'b0;
    endtask

    task automatic play_voice;
        logic [31:0] r;
        logic [15:0] vb;
        logic [7:0]  len, exp_byte, d;
        pcm_addr_t   start, exp_addr;
        int          count;
        logic        have_exp;
        r = $random(seed);
        start = r[15:0];
        len = {4'd0, r[19:16]} + 8'd1;
        vb = xmen ? 16'he800 : 16'hfa00;
        pcm_run = 1'b0;
        check_flag("nmi_n", nmi_n, 1'b1);
        bus_write({vb[15:2], `VOICE_START_LO}, start[7:0]);
        bus_write({vb[15:2], `VOICE_START_HI}, start[15:8]);
        bus_write({vb[15:2], `VOICE_LEN}, len);
        bus_write({vb[15:2], `VOICE_CTRL}, 8'h01);
        exp_addr = start;
        count = 0;
        have_exp = 1'b0;
        pcm_run = 1'b1;
        while (count < len || have_exp) begin
            @(negedge clk);
            if (have_exp) begin
                check_sample(snd, {exp_byte, 8'h00});
                have_exp = 1'b0;
            end
            check_flag("pcm_cs", pcm_cs, count < len);
            if (cen_pcm && pcm_ok && count < len) begin
                check_pcm_addr(pcm_addr, exp_addr);
                exp_byte = pcm_byte(exp_addr);  // taken on the next edge
                exp_addr = exp_addr + 1'b1;
                count++;
                have_exp = 1'b1;
            end
        end
        @(negedge clk);
        check_sample(snd, 16'sd0);
        check_flag("pcm_cs", pcm_cs, 1'b0);
        @(posedge clk);
        #5;
        bus_read({vb[15:2], `VOICE_CTRL}, d);
        check_byte("voice busy", d, 8'h00);
        pcm_run = 1'b0;
        check_flag("nmi_n", nmi_n, 1'b0);
        r = $random(seed);
        if (xmen) begin
            bus_write({6'b111110, r[9:0]}, {3'b000, 1'b1, bank_m});
            check_flag("nmi_n", nmi_n, 1'b1);
            bus_write({6'b111110, r[9:0]}, {3'b000, 1'b0, bank_m});
        end else begin
            bus_write({7'b1111110, r[8:0]}, r[23:16]);
            check_flag("nmi_n", nmi_n, 1'b1);
        end
    endtask

    initial begin
        rst       = 1'b1;
        xmen      = 1'b0;
        snd_irq   = 1'b0;
        main_addr = 2'd0;
        main_dout = 8'h00;
        main_we   = 1'b0;
        bus       = '0;
        cmd_m[0]  = 8'h00;
        cmd_m[1]  = 8'h00;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        check_flag("nmi_n", nmi_n, 1'b1);
        check_flag("int_n", int_n, 1'b1);
        check_flag("rom_cs", rom_cs, 1'b0);
        check_flag("pcm_cs", pcm_cs, 1'b0);
        check_sample(snd, 16'sd0);
        @(posedge clk);
        #5;
        xmen = 1'b1;
        @(negedge clk);
        check_flag("int_n", int_n, 1'b1);    // latch interrupt idle too
        @(posedge clk);
        #5;
        xmen = 1'b0;
        ram_write_read;
        rom_window_reads;
        latch_exchange;
        for (int mode = 0; mode < 2; mode++) begin
            xmen = mode[0];
            repeat (4) play_voice;
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
snd_pkg.sv
snd_cmd_latch.sv
snd_ram.sv
snd_pcm_voice.sv
snd_map.sv
snd_board.sv
tb_snd_board.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_snd_board \
    -o tb_snd_board > build.log 2>&1 &&
./obj_dir/tb_snd_board > sim.log 2>&1
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
